// File: rtl/isa_pkg.sv
/*
  Instruction set of the tiny 16-bit core
  Field layout, opcode encoding and register index type
*/
package isa_pkg;

  localparam int INST_WIDTH    = 16;
  localparam int OPCODE_WIDTH  = 4;
  localparam int REG_IDX_WIDTH = 3;
  localparam int IMM_WIDTH     = 8;
  localparam int NUM_REGS      = 8;

  // Low bit of each field with the immediate at bit 0
  localparam int OPCODE_LSB = 12;
  localparam int RD_LSB     = 9;
  localparam int RS1_LSB    = 6;
  localparam int RS2_LSB    = 3;

  typedef logic [INST_WIDTH-1:0]    inst_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP = 4'h0,
    OP_ADD = 4'h1,
    OP_SUB = 4'h2,
    OP_AND = 4'h3,
    OP_XOR = 4'h4,
    OP_LI  = 4'h5,
    OP_MUL = 4'h6
  } opcode_e;

endpackage

// File: rtl/pipe_pkg.sv
/*
  Pipeline definitions shared by the core stages
  Data word, decoded micro-op and multiplier latency
*/
package pipe_pkg;

  localparam int DATA_WIDTH = 16;

  // One multiplier bit is consumed per cycle
  localparam int MUL_CYCLES = 16;

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef struct packed {
    logic                            valid;
    isa_pkg::opcode_e                op;
    isa_pkg::reg_idx_t               rd;
    isa_pkg::reg_idx_t               rs1;
    isa_pkg::reg_idx_t               rs2;
    logic [isa_pkg::IMM_WIDTH-1:0]   imm;
  } uop_t;

endpackage

// File: rtl/issue_if.sv
/*
  Issue to execute hand-off
  Operation and operands go forward, the busy flag comes back
*/
`timescale 1ns/1ps

interface issue_if;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic     valid;
  opcode_e  op;
  reg_idx_t rd;
  data_t    a;
  data_t    b;
  logic     busy;

  modport issue_mp (output valid, op, rd, a, b, input busy);
  modport exec_mp  (input valid, op, rd, a, b, output busy);

endinterface

// File: rtl/inst_decode.sv
/*
  Instruction decode with a one-entry skid buffer
  Holds the next micro-op while issue stalls and raises inst_full
*/
`timescale 1ns/1ps

module inst_decode (
  input  logic            clock,
  input  logic            reset,
  input  isa_pkg::inst_t  inst,
  input  logic            inst_valid,
  input  logic            stall,
  output logic            inst_full,
  output pipe_pkg::uop_t  uop
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic    accept;
  opcode_e op;
  uop_t    decoded;
  uop_t    uop_q;
  logic    uop_valid_q;
  uop_t    skid_q;

  assign accept = inst_valid & ~inst_full;

  // Unknown opcodes behave as NOP
  always_comb begin
    case (inst[OPCODE_LSB +: OPCODE_WIDTH])
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LI, OP_MUL:
        op = opcode_e'(inst[OPCODE_LSB +: OPCODE_WIDTH]);
      default:
        op = OP_NOP;
    endcase
  end

  always_comb begin
    decoded.valid = accept & (op != OP_NOP);
    decoded.op    = op;
    decoded.rd    = inst[RD_LSB +: REG_IDX_WIDTH];
    decoded.rs1   = inst[RS1_LSB +: REG_IDX_WIDTH];
    decoded.rs2   = inst[RS2_LSB +: REG_IDX_WIDTH];
    decoded.imm   = inst[IMM_WIDTH-1:0];
  end

  // Store when issue is stalled, replay the skid entry first once it frees up
  always_ff @(posedge clock) begin
    if (reset) begin
      uop_valid_q <= 1'b0;
      inst_full   <= 1'b0;
    end else if (stall) begin
      if (decoded.valid) begin
        inst_full <= 1'b1;
      end
    end else if (inst_full) begin
      uop_valid_q <= 1'b1;
      inst_full   <= 1'b0;
    end else begin
      uop_valid_q <= decoded.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (stall) begin
      if (decoded.valid) begin
        skid_q <= decoded;
      end
    end else if (inst_full) begin
      uop_q <= skid_q;
    end else begin
      uop_q <= decoded;
    end
  end

  always_comb begin
    uop       = uop_q;
    uop.valid = uop_valid_q;
  end

endmodule

// File: rtl/scoreboard.sv
/*
  Register busy scoreboard
  Bit is set when a writer issues and cleared at its writeback
*/
`timescale 1ns/1ps

module scoreboard (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           set_valid,
  input  isa_pkg::reg_idx_t              set_rd,
  input  logic                           clear_valid,
  input  isa_pkg::reg_idx_t              clear_rd,
  output logic [isa_pkg::NUM_REGS-1:0]   busy
);
  import isa_pkg::*;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (clear_valid) begin
        busy[clear_rd] <= 1'b0;
      end
      // Set comes last so it wins on the same register
      if (set_valid) begin
        busy[set_rd] <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/issue_stage.sv
/*
  Issue stage with register file and hazard check
  Issues the decode output when its registers and execute are free
*/
`timescale 1ns/1ps

module issue_stage (
  input  logic               clock,
  input  logic               reset,
  input  pipe_pkg::uop_t     uop,
  output logic               stall,
  input  logic               wb_valid,
  input  isa_pkg::reg_idx_t  wb_rd,
  input  pipe_pkg::data_t    wb_data,
  issue_if.issue_mp          issue
);
  import isa_pkg::*;
  import pipe_pkg::*;

  data_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;
  logic                src_ready;
  logic                ready;

  scoreboard u_scoreboard (
    .clock       (clock      ),
    .reset       (reset      ),
    .set_valid   (issue.valid),
    .set_rd      (uop.rd     ),
    .clear_valid (wb_valid   ),
    .clear_rd    (wb_rd      ),
    .busy        (busy       )
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // LI has no source registers
  assign src_ready = (uop.op == OP_LI) | (~busy[uop.rs1] & ~busy[uop.rs2]);
  assign ready     = src_ready & ~busy[uop.rd] & ~issue.busy;

  assign stall       = uop.valid & ~ready;
  assign issue.valid = uop.valid & ready;
  assign issue.op    = uop.op;
  assign issue.rd    = uop.rd;
  assign issue.a     = regs[uop.rs1];
  assign issue.b     = (uop.op == OP_LI) ? DATA_WIDTH'(uop.imm) : regs[uop.rs2];

endmodule

// File: rtl/mul_unit.sv
/*
  Iterative shift-add multiplier
  One multiplier bit per cycle, keeps the low 16 bits of the product
*/
`timescale 1ns/1ps

module mul_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  pipe_pkg::data_t  a,
  input  pipe_pkg::data_t  b,
  output logic             done,
  output pipe_pkg::data_t  product
);
  import pipe_pkg::*;

  localparam int CNT_WIDTH = $clog2(MUL_CYCLES);

  logic                 running;
  logic [CNT_WIDTH-1:0] count;
  data_t                acc;
  data_t                mcand;
  data_t                mplier;

  always_ff @(posedge clock) begin
    if (reset) begin
      running <= 1'b0;
      count   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        count   <= '0;
      end else if (running) begin
        count <= count + 1'b1;
        if (count == CNT_WIDTH'(MUL_CYCLES - 1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      acc    <= '0;
      mcand  <= a;
      mplier <= b;
    end else if (running) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign product = acc;

endmodule

// File: rtl/exec_unit.sv
/*
  Execute stage with single-cycle ALU and multiplier hand-off
  Owns the writeback register and the busy flag back to issue
*/
`timescale 1ns/1ps

module exec_unit (
  input  logic               clock,
  input  logic               reset,
  issue_if.exec_mp           issue,
  output logic               wb_valid,
  output isa_pkg::reg_idx_t  wb_rd,
  output pipe_pkg::data_t    wb_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic     mul_start;
  logic     mul_busy;
  logic     mul_done;
  reg_idx_t mul_rd;
  data_t    mul_product;
  data_t    alu_result;

  mul_unit u_mul (
    .clock   (clock      ),
    .reset   (reset      ),
    .start   (mul_start  ),
    .a       (issue.a    ),
    .b       (issue.b    ),
    .done    (mul_done   ),
    .product (mul_product)
  );

  assign mul_start  = issue.valid & (issue.op == OP_MUL);
  assign issue.busy = mul_busy;

  always_comb begin
    case (issue.op)
      OP_ADD:  alu_result = issue.a + issue.b;
      OP_SUB:  alu_result = issue.a - issue.b;
      OP_AND:  alu_result = issue.a & issue.b;
      OP_XOR:  alu_result = issue.a ^ issue.b;
      OP_LI:   alu_result = issue.b;
      default: alu_result = '0;
    endcase
  end

  // Busy holds through the done cycle so an ALU result never collides
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
      mul_busy <= 1'b0;
    end else begin
      wb_valid <= mul_done | (issue.valid & ~mul_start);
      if (mul_start) begin
        mul_busy <= 1'b1;
      end else if (mul_done) begin
        mul_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mul_start) begin
      mul_rd <= issue.rd;
    end
    if (mul_done) begin
      wb_rd   <= mul_rd;
      wb_data <= mul_product;
    end else if (issue.valid) begin
      wb_rd   <= issue.rd;
      wb_data <= alu_result;
    end
  end

endmodule

// File: rtl/core_top.sv
/*
  Core top level
  Decode, issue and execute stages; writeback doubles as retire
*/
`timescale 1ns/1ps

module core_top (
  input  logic               clock,
  input  logic               reset,
  input  isa_pkg::inst_t     inst,
  input  logic               inst_valid,
  output logic               inst_full,
  output logic               retire_valid,
  output isa_pkg::reg_idx_t  retire_rd,
  output pipe_pkg::data_t    retire_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  uop_t     uop;
  logic     stall;
  logic     wb_valid;
  reg_idx_t wb_rd;
  data_t    wb_data;

  issue_if issue_bus ();

  inst_decode u_decode (
    .clock      (clock     ),
    .reset      (reset     ),
    .inst       (inst      ),
    .inst_valid (inst_valid),
    .stall      (stall     ),
    .inst_full  (inst_full ),
    .uop        (uop       )
  );

  issue_stage u_issue (
    .clock    (clock    ),
    .reset    (reset    ),
    .uop      (uop      ),
    .stall    (stall    ),
    .wb_valid (wb_valid ),
    .wb_rd    (wb_rd    ),
    .wb_data  (wb_data  ),
    .issue    (issue_bus)
  );

  exec_unit u_exec (
    .clock    (clock    ),
    .reset    (reset    ),
    .issue    (issue_bus),
    .wb_valid (wb_valid ),
    .wb_rd    (wb_rd    ),
    .wb_data  (wb_data  )
  );

  assign retire_valid = wb_valid;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

endmodule

// File: tb/core_properties.sv
/*
  Concurrent assertions bound to the core top level
  Reset quiet, issue hand-off, scoreboard clear and retire data checks
*/
`timescale 1ns/1ps

module core_properties (
  input logic                          clock,
  input logic                          reset,
  input logic                          retire_valid,
  input isa_pkg::reg_idx_t             retire_rd,
  input pipe_pkg::data_t               retire_data,
  input logic                          issue_valid,
  input isa_pkg::opcode_e              issue_op,
  input logic                          issue_busy,
  input logic [isa_pkg::NUM_REGS-1:0]  sb_busy
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Quiet during reset and for one cycle after it
  retire_quiet_after_reset: assert property (
    @(posedge clock) (reset || $past(reset)) |=> !retire_valid
  ) else $error("retire_valid high during reset or right after it");

  // A MUL makes execute busy so nothing issues right behind it
  no_issue_while_busy: assert property (
    @(posedge clock) disable iff (reset)
      (issue_valid && issue_op == OP_MUL) |=> (issue_busy && !issue_valid)
  ) else $error("execute not busy or a new issue right after a MUL");

  // Writeback must hit a register that is marked busy
  clear_only_busy_reg: assert property (
    @(posedge clock) disable iff (reset) retire_valid |-> sb_busy[retire_rd]
  ) else $error("writeback to a register that is not busy");

  retire_data_known: assert property (
    @(posedge clock) disable iff (reset) retire_valid |-> !$isunknown(retire_data)
  ) else $error("retire_data unknown while retire_valid is high");

endmodule

bind core_top core_properties u_props (
  .clock        (clock          ),
  .reset        (reset          ),
  .retire_valid (retire_valid   ),
  .retire_rd    (retire_rd      ),
  .retire_data  (retire_data    ),
  .issue_valid  (issue_bus.valid),
  .issue_op     (issue_bus.op   ),
  .issue_busy   (issue_bus.busy ),
  .sb_busy      (u_issue.busy   )
);

// File: tb/core_tb.sv
/*
  Testbench for the core top level
  Feeds instruction vectors with random gaps and checks every retire in order
*/
`timescale 1ns/1ps

module core_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int NUM_VECTORS    = 22;
  localparam int FIELDS         = 4;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * (MUL_CYCLES + 8) + 100;
  localparam int DRAIN_CYCLES   = 4 * MUL_CYCLES;

  logic     clock;
  logic     reset;
  inst_t    inst;
  logic     inst_valid;
  logic     inst_full;
  logic     retire_valid;
  reg_idx_t retire_rd;
  data_t    retire_data;

  // Four words per vector hold instruction, expect flag, rd and data
  logic [15:0] vec_mem [NUM_VECTORS*FIELDS];
  reg_idx_t    exp_rd_q [$];
  data_t       exp_data_q [$];
  int          cycle_count = 0;

  core_top uut (
    .clock        (clock       ),
    .reset        (reset       ),
    .inst         (inst        ),
    .inst_valid   (inst_valid  ),
    .inst_full    (inst_full   ),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd   ),
    .retire_data  (retire_data )
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped after an error");
  endtask

  task automatic check_rd(input reg_idx_t actual, input reg_idx_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %0t retire_rd got %0d expected %0d",
                          $time, actual, expected));
    end
  endtask

  task automatic check_data(input data_t actual, input data_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %0t retire_data got %h expected %h",
                          $time, actual, expected));
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("ERR %0t %s got %b expected %b",
                          $time, name, actual, expected));
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clock) begin
    if (!reset && retire_valid) begin
      if (exp_rd_q.size() == 0) begin
        abort_run("A result retired although no instruction was left to retire");
      end else begin
        check_rd(retire_rd, exp_rd_q.pop_front());
        check_data(retire_data, exp_data_q.pop_front());
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout, the run went past %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    int gap;
    void'($urandom(8450));
    reset      = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    $readmemh("tb/core_vectors.txt", vec_mem);
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (vec_mem[i*FIELDS+1] == 16'h0001) begin
        exp_rd_q.push_back(reg_idx_t'(vec_mem[i*FIELDS+2]));
        exp_data_q.push_back(vec_mem[i*FIELDS+3]);
      end
    end

    repeat (8) @(negedge clock);
    reset = 1'b0;

    // Nothing retires or fills before the first instruction
    repeat (3) begin
      @(negedge clock);
      compare_flag("retire_valid", retire_valid, 1'b0);
      compare_flag("inst_full", inst_full, 1'b0);
    end

    for (int i = 0; i < NUM_VECTORS; i++) begin
      gap = $urandom_range(3, 0);
      if (gap > 0) begin
        inst_valid = 1'b0;
        repeat (gap) @(negedge clock);
      end
      inst       = vec_mem[i*FIELDS];
      inst_valid = 1'b1;
      // inst_full is stable here and decides the coming rising edge
      while (inst_full) begin
        @(negedge clock);
      end
      @(negedge clock);
    end
    inst_valid = 1'b0;

    for (int k = 0; k < DRAIN_CYCLES && exp_rd_q.size() != 0; k++) begin
      @(posedge clock);
    end
    // Extra cycles so a stray retire still gets caught
    repeat (MUL_CYCLES + 4) @(posedge clock);
    if (exp_rd_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("%0d expected results never retired", exp_rd_q.size()));
    end
  end

endmodule

// File: tb/core_vectors.txt
// Columns: instruction word, expect flag (1 = retires), expected rd, expected data
// Registers start at zero, values follow program order
5205 1 1 0005
5403 1 2 0003
1650 1 3 0008
2850 1 4 0002
3A50 1 5 0001
4C50 1 6 0006
2E88 1 7 FFFE
12D8 1 1 0010
1248 1 1 0020
4478 1 2 FFDE
0000 0 0 0000
6690 1 3 0484
18C8 1 4 04A4
5AFF 1 5 00FF
6D68 1 6 FE01
5012 1 0 0012
F123 0 0 0000
6FA0 1 7 BCA4
1038 1 0 BCB6
7000 0 0 0000
33F0 1 1 BC00
4408 1 2 00B6

// File: build.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/issue_if.sv
rtl/inst_decode.sv
rtl/scoreboard.sv
rtl/issue_stage.sv
rtl/mul_unit.sv
rtl/exec_unit.sv
rtl/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f build.f -o core_sim
./obj_dir/core_sim
